// ==== Makefile ====
# Verilator simulation of the transport-stream packet replacer

TOP = tb_ts_replacer

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, log in sim.log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@if grep -q "Done: errors found" sim.log; then echo "FAIL: see sim.log"; exit 1; fi
	@if ! grep -q "Done: no errors" sim.log; then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
source/ts_replacer_pkg.sv
source/packet_store.sv
source/ts_header_matcher.sv
source/ts_splicer.sv
source/ts_replacer_top.sv
tb/ts_replacer_props.sv
tb/tb_ts_replacer.sv

// ==== source/packet_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module packet_store import ts_replacer_pkg::*; (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,

	input wire save_replace_data_enable,
	input wire [word_width-1:0] in_data,
	input wire word_addr_t in_data_index,

	input wire pump_data_enable,
	output logic [word_width-1:0] out_data,
	output word_addr_t out_data_index,
	output logic ready_for_read,

	input wire word_addr_t rd_addr,
	output ts_word_u rd_word
);

	ts_word_u mem [0:ts_packet_words-1];

	word_addr_t pump_idx;
	logic pump_in_range;
	logic wr_in_range;

	assign wr_in_range = (in_data_index < word_addr_t'(ts_packet_words));
	assign pump_in_range = (pump_idx < word_addr_t'(ts_packet_words));

	// Software writes beyond the packet are dropped
	always_ff @(posedge S_AXI_ACLK) begin
		if (save_replace_data_enable && wr_in_range) begin
			mem[in_data_index].word <= in_data;
		end
	end

	// Word pump walks the store once per assertion of the enable
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			pump_idx <= '0;
			out_data_index <= '0;
			ready_for_read <= 1'b0;
		end else begin
			if (pump_data_enable) begin
				if (pump_in_range) begin
					out_data_index <= pump_idx;
					pump_idx <= pump_idx + 1'b1;
					ready_for_read <= 1'b0;
				end else begin
					ready_for_read <= 1'b1;
				end
			end else begin
				pump_idx <= '0;
				ready_for_read <= 1'b0;
			end
		end
	end

	// The pumped word leaves on the same edge as its index
	always_ff @(posedge S_AXI_ACLK) begin
		if (pump_data_enable && pump_in_range) begin
			out_data <= mem[pump_idx].word;
		end
	end

	// The splicer reads asynchronously and keeps rd_addr inside the packet
	always_comb begin
		rd_word = mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== source/ts_header_matcher.sv ====
`timescale 1ns/100ps
`default_nettype none

module ts_header_matcher import ts_replacer_pkg::*; (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,

	input wire [7:0] mpeg_data,
	input wire mpeg_valid,
	input wire mpeg_sync,

	input wire [pid_width-1:0] pid,
	input wire run_enable,

	output logic hdr_match,
	output logic hdr_mismatch,

	output logic [7:0] dly_byte,
	output logic dly_valid
);

	logic [7:0] data_d1;
	logic [7:0] data_d2;
	logic [7:0] data_d3;
	logic sync_d1;
	logic sync_d2;
	logic [1:0] fill_cnt;

	logic hdr_seen;
	logic pid_equal;
	logic [pid_width-1:0] rx_pid;

	// Byte stages carry payload only
	always_ff @(posedge S_AXI_ACLK) begin
		if (mpeg_valid) begin
			data_d1 <= mpeg_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	// Sync flags and the fill count tell which stages hold real bytes
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
			fill_cnt <= '0;
		end else if (mpeg_valid) begin
			sync_d1 <= mpeg_sync;
			sync_d2 <= sync_d1;
			if (fill_cnt != 2'd3) begin
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	// The PID spans the low bits of header byte 1 and all of header byte 2
	assign rx_pid = {data_d1[pid_width-9:0], mpeg_data};
	assign pid_equal = (rx_pid == pid);
	assign hdr_seen = mpeg_valid && sync_d2 && (data_d2 == ts_sync_byte);

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			hdr_match <= 1'b0;
			hdr_mismatch <= 1'b0;
		end else begin
			hdr_match <= hdr_seen && pid_equal && run_enable;
			hdr_mismatch <= hdr_seen && !(pid_equal && run_enable);
		end
	end

	// Oldest stage leaves on the strobe that pushes in a new byte
	assign dly_byte = data_d3;
	assign dly_valid = mpeg_valid && (fill_cnt == 2'd3);

endmodule

`default_nettype wire

// ==== source/ts_replacer_pkg.sv ====
`default_nettype none

package ts_replacer_pkg;

	// Packet geometry of an MPEG transport stream
	localparam int ts_packet_bytes = 188;
	localparam int ts_packet_words = 47;
	localparam logic [7:0] ts_sync_byte = 8'h47;
	localparam int pid_width = 13;

	// Byte indexing inside a word assumes exactly four bytes per word
	localparam int word_width = 32;

	typedef logic [5:0] word_addr_t;
	typedef logic [7:0] byte_addr_t;

	// One store word, seen either as the software word or as its four bytes
	// Packet byte k sits in byte k mod 4 of word k/4, lowest byte first
	typedef union packed {
		logic [word_width-1:0] word;
		logic [3:0][7:0] bytes;
	} ts_word_u;

endpackage

`default_nettype wire

// ==== source/ts_replacer_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ts_replacer_top import ts_replacer_pkg::*; (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,

	input wire base_data,
	input wire run_enable,

	input wire save_replace_data_enable,
	input wire [word_width-1:0] in_data,
	input wire word_addr_t in_data_index,

	input wire pump_data_enable,
	output logic [word_width-1:0] out_data,
	output word_addr_t out_data_index,
	output logic ready_for_read,

	input wire [pid_width-1:0] pid,
	input wire [7:0] mpeg_data,
	input wire mpeg_valid,
	input wire mpeg_sync,

	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic matched_state
);

	logic hdr_match;
	logic hdr_mismatch;
	logic [7:0] dly_byte;
	logic dly_valid;
	word_addr_t rd_addr;
	ts_word_u rd_word;

	packet_store u_store (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.save_replace_data_enable(save_replace_data_enable),
		.in_data(in_data),
		.in_data_index(in_data_index),
		.pump_data_enable(pump_data_enable),
		.out_data(out_data),
		.out_data_index(out_data_index),
		.ready_for_read(ready_for_read),
		.rd_addr(rd_addr),
		.rd_word(rd_word)
	);

	ts_header_matcher u_matcher (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.pid(pid),
		.run_enable(run_enable),
		.hdr_match(hdr_match),
		.hdr_mismatch(hdr_mismatch),
		.dly_byte(dly_byte),
		.dly_valid(dly_valid)
	);

	// The splicer picks between the delayed stream and the stored packet
	ts_splicer u_splicer (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.base_data(base_data),
		.hdr_match(hdr_match),
		.hdr_mismatch(hdr_mismatch),
		.dly_byte(dly_byte),
		.dly_valid(dly_valid),
		.rd_addr(rd_addr),
		.rd_word(rd_word),
		.ts_out(ts_out),
		.ts_out_valid(ts_out_valid),
		.matched_state(matched_state)
	);

endmodule

`default_nettype wire

// ==== source/ts_splicer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ts_splicer import ts_replacer_pkg::*; (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,

	input wire base_data,
	input wire hdr_match,
	input wire hdr_mismatch,

	input wire [7:0] dly_byte,
	input wire dly_valid,

	output word_addr_t rd_addr,
	input wire ts_word_u rd_word,

	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic matched_state
);

	logic replay;
	byte_addr_t replay_cnt;
	logic cnt_in_range;
	logic emit;

	assign cnt_in_range = (replay_cnt < byte_addr_t'(ts_packet_bytes));
	assign emit = !base_data && replay && cnt_in_range;

	// rd_addr follows the replay byte and rests at word 0 once the packet is done
	assign rd_addr = cnt_in_range ? replay_cnt[7:2] : '0;

	// A new match restarts the packet even while a replay is still running
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			replay <= 1'b0;
			replay_cnt <= '0;
		end else begin
			if (hdr_match) begin
				replay <= 1'b1;
				replay_cnt <= '0;
			end else if (hdr_mismatch) begin
				replay <= 1'b0;
			end else if (emit) begin
				replay_cnt <= replay_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ts_out_valid <= 1'b0;
			matched_state <= 1'b0;
		end else if (base_data) begin
			ts_out_valid <= dly_valid;
			matched_state <= 1'b1;
		end else begin
			ts_out_valid <= emit;
			matched_state <= replay;
		end
	end

	// The output byte comes from the delay line or from the store
	always_ff @(posedge S_AXI_ACLK) begin
		if (base_data) begin
			if (dly_valid) begin
				ts_out <= dly_byte;
			end
		end else if (emit) begin
			ts_out <= rd_word.bytes[replay_cnt[1:0]];
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_ts_replacer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ts_replacer import ts_replacer_pkg::*; ();

	localparam logic [pid_width-1:0] run_pid = 13'h1a5c;
	localparam logic [pid_width-1:0] other_pid = 13'h0123;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic base_data;
	logic run_enable;
	logic save_replace_data_enable;
	logic [word_width-1:0] in_data;
	word_addr_t in_data_index;
	logic pump_data_enable;
	logic [word_width-1:0] out_data;
	word_addr_t out_data_index;
	logic ready_for_read;
	logic [pid_width-1:0] pid;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic [7:0] ts_out;
	logic ts_out_valid;
	logic matched_state;

	logic [15:0] lfsr_state;
	logic [word_width-1:0] loaded [0:ts_packet_words-1];
	logic [7:0] expected [$];
	logic need_unmatched;
	int checks;
	int mismatches;
	int other_errors;

	ts_replacer_top i_dut (.*);

	bind ts_splicer ts_replacer_props u_props (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.base_data(base_data),
		.hdr_match(hdr_match),
		.hdr_mismatch(hdr_mismatch),
		.replay(replay),
		.rd_addr(rd_addr),
		.ts_out_valid(ts_out_valid)
	);

	initial S_AXI_ACLK = 1'b0;
	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	// Taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[15]};
		end
	endtask

	// Packet byte k is byte k mod 4 of stored word k/4 and byte 0 is the lowest
	function automatic logic [7:0] store_byte(input int k);
		return loaded[k / 4][8 * (k % 4) +: 8];
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	// Header bytes carry sync and PID and the rest of the packet is random
	task automatic send_packet(input logic [pid_width-1:0] hdr_pid, input bit keep);
		logic [31:0] r;
		logic [7:0] b;
		for (int i = 0; i < ts_packet_bytes; i++) begin
			case (i)
				0: b = ts_sync_byte;
				1: b = {3'b000, hdr_pid[12:8]};
				2: b = hdr_pid[7:0];
				default: begin
					take_bits(8, r);
					b = r[7:0];
				end
			endcase
			mpeg_data = b;
			mpeg_valid = 1'b1;
			mpeg_sync = (i == 0);
			if (keep) begin
				expected.push_back(b);
			end
			next_cycle();
		end
	endtask

	task automatic stream_idle();
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
	endtask

	task automatic wait_drain(input int limit, input string what);
		int n;
		n = 0;
		while (expected.size() != 0 && n < limit) begin
			next_cycle();
			n++;
		end
		if (expected.size() != 0) begin
			$display("Timeout in %s: %0d expected bytes never came out", what, expected.size());
			other_errors++;
			expected.delete();
		end
		// A few idle cycles catch any surplus output
		repeat (8) next_cycle();
	endtask

	always @(negedge S_AXI_ACLK) begin
		if (S_AXI_ARESETN && ts_out_valid) begin
			if (expected.size() == 0) begin
				$display("Unexpected output byte %h at %0t ns", ts_out, $time);
				other_errors++;
			end else begin
				check_value("ts_out", 32'(ts_out), 32'(expected.pop_front()));
			end
		end
		if (need_unmatched) begin
			check_value("matched_state", 32'(matched_state), 32'd0);
		end
	end

	initial begin
		#1_000_000;
		$display("Simulation ran past its time limit");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		logic [31:0] word;
		int n;
		S_AXI_ARESETN = 1'b0;
		base_data = 1'b1;
		run_enable = 1'b0;
		save_replace_data_enable = 1'b0;
		in_data = '0;
		in_data_index = '0;
		pump_data_enable = 1'b0;
		pid = run_pid;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		lfsr_state = 16'd22;
		need_unmatched = 1'b0;
		checks = 0;
		mismatches = 0;
		other_errors = 0;
		repeat (4) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		next_cycle();

		// Load the replacement packet and then write once past its end
		for (int k = 0; k < ts_packet_words; k++) begin
			take_bits(32, word);
			loaded[k] = word;
			save_replace_data_enable = 1'b1;
			in_data = word;
			in_data_index = word_addr_t'(k);
			next_cycle();
		end
		in_data = 32'hffff_ffff;
		in_data_index = 6'd50;
		next_cycle();
		save_replace_data_enable = 1'b0;

		pump_data_enable = 1'b1;
		for (int k = 0; k < ts_packet_words; k++) begin
			@(posedge S_AXI_ACLK);
			@(negedge S_AXI_ACLK);
			check_value("out_data_index", 32'(out_data_index), 32'(k));
			check_value("out_data", out_data, loaded[k]);
		end
		n = 0;
		while (!ready_for_read && n < 60) begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (!ready_for_read) begin
			$display("Timeout: ready_for_read never rose after the pump");
			other_errors++;
		end
		repeat (5) begin
			@(negedge S_AXI_ACLK);
			check_value("ready_for_read", 32'(ready_for_read), 32'd1);
		end
		next_cycle();
		pump_data_enable = 1'b0;
		@(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		check_value("ready_for_read", 32'(ready_for_read), 32'd0);
		next_cycle();

		// Passthrough keeps the last three bytes in the delay line
		send_packet(run_pid, 1'b1);
		send_packet(run_pid, 1'b1);
		stream_idle();
		repeat (3) void'(expected.pop_back());
		wait_drain(20, "passthrough");
		check_value("matched_state", 32'(matched_state), 32'd1);

		base_data = 1'b0;
		run_enable = 1'b1;
		next_cycle();
		next_cycle();
		need_unmatched = 1'b1;
		send_packet(other_pid, 1'b0);
		run_enable = 1'b0;
		send_packet(run_pid, 1'b0);
		stream_idle();
		repeat (8) next_cycle();
		need_unmatched = 1'b0;

		run_enable = 1'b1;
		for (int k = 0; k < ts_packet_bytes; k++) begin
			expected.push_back(store_byte(k));
		end
		send_packet(run_pid, 1'b0);
		stream_idle();
		wait_drain(300, "replacement");
		check_value("matched_state", 32'(matched_state), 32'd1);

		for (int k = 0; k < 2 * ts_packet_bytes; k++) begin
			expected.push_back(store_byte(k % ts_packet_bytes));
		end
		send_packet(run_pid, 1'b0);
		send_packet(run_pid, 1'b0);
		stream_idle();
		wait_drain(300, "back-to-back replacement");
		send_packet(other_pid, 1'b0);
		stream_idle();
		n = 0;
		while (matched_state && n < 20) begin
			next_cycle();
			n++;
		end
		check_value("matched_state", 32'(matched_state), 32'd0);
		repeat (8) next_cycle();

		$display("Summary: %0d checks, %0d mismatches, %0d other errors",
			checks, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/ts_replacer_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module ts_replacer_props import ts_replacer_pkg::*; (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire base_data,
	input wire hdr_match,
	input wire hdr_mismatch,
	input wire replay,
	input wire word_addr_t rd_addr,
	input wire ts_out_valid
);

	// Synchronous reset clears the output strobe on the following edge
	reset_clears_valid: assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> !ts_out_valid)
		else $error("ts_out_valid high after a reset cycle");

	rd_addr_in_packet: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rd_addr < word_addr_t'(ts_packet_words))
		else $error("rd_addr points past the packet store");

	// In replacement mode a valid byte can only come from a running replay
	valid_needs_replay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		ts_out_valid && !$past(base_data) |-> $past(replay))
		else $error("ts_out_valid in replacement mode without replay state");

	hdr_flags_exclusive: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(hdr_match && hdr_mismatch))
		else $error("hdr_match and hdr_mismatch high together");

endmodule

`default_nettype wire
